// ==== Bender.yml ====
package:
  name: fault_monitor

sources:
  - rtl/fault_pkg.sv
  - rtl/color_debounce.sv
  - rtl/patrol_fsm.sv
  - rtl/led_slots.sv
  - rtl/message_builder.sv
  - rtl/blink_timer.sv
  - rtl/fault_monitor_top.sv
  - target: simulation
    files:
      - testbench/tb_fault_monitor.sv

// ==== files.f ====
rtl/fault_pkg.sv
rtl/color_debounce.sv
rtl/patrol_fsm.sv
rtl/led_slots.sv
rtl/message_builder.sv
rtl/blink_timer.sv
rtl/fault_monitor_top.sv
testbench/tb_fault_monitor.sv

// ==== rtl/blink_timer.sv ====
// both cycle parameters must be at least 1 and every on phase restarts at red
`timescale 1ns/1ns
`default_nettype none

module blink_timer #(
	parameter int BLINK_PHASE_CYCLES = 50000000,
	parameter int BLINK_STEP_CYCLES  = 180000
) (
	input  logic              CLOCK,
	input  logic              arst_n,
	input  logic              blink_run,
	output logic              blink_on,
	output fault_pkg::color_t blink_color
);

	import fault_pkg::*;

	localparam int PHASE_W = $clog2(BLINK_PHASE_CYCLES + 1);
	localparam int STEP_W  = $clog2(BLINK_STEP_CYCLES + 1);

	logic [PHASE_W-1:0] phase_cnt;
	logic [STEP_W-1:0]  step_cnt;
	logic               phase_end;
	logic               step_end;

	assign phase_end = (phase_cnt == PHASE_W'(BLINK_PHASE_CYCLES - 1));
	assign step_end  = (step_cnt == STEP_W'(BLINK_STEP_CYCLES - 1));

	always_ff @(posedge CLOCK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phase_cnt   <= '0;
			step_cnt    <= '0;
			blink_on    <= 1'b1;  // first phase lit
			blink_color <= COLOR_RED;
		end
		else if (!blink_run)
		begin
			phase_cnt   <= '0;  // parked until end of run
			step_cnt    <= '0;
			blink_on    <= 1'b1;
			blink_color <= COLOR_RED;
		end
		else
		begin
			if (phase_end)
			begin
				phase_cnt <= '0;
				blink_on  <= !blink_on;
			end
			else
				phase_cnt <= phase_cnt + PHASE_W'(1);

			if (!blink_on || phase_end)
			begin
				step_cnt    <= '0;
				blink_color <= COLOR_RED;
			end
			else if (step_end)
			begin
				step_cnt <= '0;
				case (blink_color)  // red then green then blue
					COLOR_RED:   blink_color <= COLOR_GREEN;
					COLOR_GREEN: blink_color <= COLOR_BLUE;
					default:     blink_color <= COLOR_RED;
				endcase
			end
			else
				step_cnt <= step_cnt + STEP_W'(1);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/color_debounce.sv ====
// samples count only on color_valid and a run must exceed DEBOUNCE_LEN before one confirm is issued
`timescale 1ns/1ns
`default_nettype none

module color_debounce #(
	parameter int DEBOUNCE_LEN = 15
) (
	input  logic             CLOCK,
	input  logic             arst_n,
	input  fault_pkg::color_t color,
	input  logic             color_valid,
	output logic             confirm,
	output fault_pkg::color_t confirm_color
);

	import fault_pkg::*;

	localparam int RUN_W = $clog2(DEBOUNCE_LEN + 2);  // room for DEBOUNCE_LEN+1

	color_t           prev_color;  // last valid sample
	logic [RUN_W-1:0] run_cnt;     // length of the current run
	logic [RUN_W-1:0] run_next;

	// a new colour starts its own run at one
	assign run_next = (color == prev_color) ? run_cnt + RUN_W'(1) : RUN_W'(1);

	always_ff @(posedge CLOCK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prev_color <= COLOR_WHITE;
			run_cnt    <= '0;
			confirm    <= 1'b0;
		end
		else
		begin
			confirm <= 1'b0;  // pulse only
			if (color_valid)
			begin
				prev_color <= color;
				if (run_next > RUN_W'(DEBOUNCE_LEN))
				begin
					confirm <= 1'b1;
					run_cnt <= '0;  // next confirm needs a fresh run
				end
				else
					run_cnt <= run_next;
			end
		end
	end

	always_ff @(posedge CLOCK)
	begin
		if (color_valid)
			confirm_color <= color;  // held with the pulse
	end

	a_confirm_pulse: assert property (@(posedge CLOCK) disable iff (!arst_n)
		confirm |=> !confirm)
		else $error("confirm held for two cycles");

endmodule

`default_nettype wire

// ==== rtl/fault_monitor_top.sv ====
// msg_valid and the led update land two cycles after a confirm and the uart and colour sensor sit outside
`timescale 1ns/1ns
`default_nettype none

module fault_monitor_top #(
	parameter int DEBOUNCE_LEN       = 15,
	parameter int BLINK_PHASE_CYCLES = 50000000,
	parameter int BLINK_STEP_CYCLES  = 180000
) (
	input  logic                CLOCK,
	input  logic                arst_n,
	input  logic                in_scan,
	input  fault_pkg::unit_t    unit,
	input  logic                is_stop,
	input  fault_pkg::color_t   color,
	input  logic                color_valid,
	input  logic                tx_done,
	output fault_pkg::led_t     led1,
	output fault_pkg::led_t     led2,
	output fault_pkg::led_t     led3,
	output fault_pkg::msg_t     msg_data,
	output fault_pkg::nbytes_t  msg_bytes,
	output logic [2:0]          msg_repeat,
	output logic                msg_valid,
	output fault_pkg::visits_t  visits_mpu,
	output fault_pkg::visits_t  visits_pu,
	output fault_pkg::visits_t  visits_w
);

	logic              confirm;
	fault_pkg::color_t confirm_color;
	logic              fill_req;
	logic              clear_req;
	logic              report;
	fault_pkg::color_t req_color;    // also the reported colour
	fault_pkg::unit_t  report_unit;
	logic              slot_free;
	logic [1:0]        cleared_n;
	logic              blink_run;
	logic              blink_on;
	fault_pkg::color_t blink_color;

	color_debounce #(
		.DEBOUNCE_LEN (DEBOUNCE_LEN)
	) i_debounce (
		.CLOCK         (CLOCK),
		.arst_n        (arst_n),
		.color         (color),
		.color_valid   (color_valid),
		.confirm       (confirm),
		.confirm_color (confirm_color)
	);

	patrol_fsm i_fsm (
		.CLOCK         (CLOCK),
		.arst_n        (arst_n),
		.in_scan       (in_scan),
		.is_stop       (is_stop),
		.unit          (unit),
		.confirm       (confirm),
		.confirm_color (confirm_color),
		.tx_done       (tx_done),
		.slot_free     (slot_free),
		.fill_req      (fill_req),
		.clear_req     (clear_req),
		.report        (report),
		.req_color     (req_color),
		.report_unit   (report_unit),
		.blink_run     (blink_run),
		.visits_mpu    (visits_mpu),
		.visits_pu     (visits_pu),
		.visits_w      (visits_w)
	);

	led_slots i_leds (
		.CLOCK       (CLOCK),
		.arst_n      (arst_n),
		.fill_req    (fill_req),
		.clear_req   (clear_req),
		.req_color   (req_color),
		.blink_run   (blink_run),
		.blink_on    (blink_on),
		.blink_color (blink_color),
		.slot_free   (slot_free),
		.cleared_n   (cleared_n),
		.led1        (led1),
		.led2        (led2),
		.led3        (led3)
	);

	message_builder i_msg (
		.CLOCK        (CLOCK),
		.arst_n       (arst_n),
		.report       (report),
		.report_unit  (report_unit),
		.report_color (req_color),
		.cleared_n    (cleared_n),
		.msg_data     (msg_data),
		.msg_bytes    (msg_bytes),
		.msg_repeat   (msg_repeat),
		.msg_valid    (msg_valid)
	);

	blink_timer #(
		.BLINK_PHASE_CYCLES (BLINK_PHASE_CYCLES),
		.BLINK_STEP_CYCLES  (BLINK_STEP_CYCLES)
	) i_blink (
		.CLOCK       (CLOCK),
		.arst_n      (arst_n),
		.blink_run   (blink_run),
		.blink_on    (blink_on),
		.blink_color (blink_color)
	);

endmodule

`default_nettype wire

// ==== rtl/fault_pkg.sv ====
// message text is stored byte-reversed so the first character sits in the low byte for an lsb-first transmitter
`default_nettype none

package fault_pkg;

	typedef logic [2:0]  color_t;   // sensor colour code
	typedef logic [2:0]  led_t;     // active low rgb drive
	typedef logic [2:0]  unit_t;    // patrol unit code
	typedef logic [95:0] msg_t;     // up to 12 ascii bytes
	typedef logic [3:0]  nbytes_t;  // bytes in one record
	typedef logic [4:0]  tally_t;   // faults seen so far in a unit
	typedef logic [1:0]  visits_t;  // visits still wanted

	localparam color_t COLOR_WHITE = 3'd0;  // no patch under the sensor
	localparam color_t COLOR_RED   = 3'd1;
	localparam color_t COLOR_GREEN = 3'd2;
	localparam color_t COLOR_BLUE  = 3'd3;

	localparam led_t LED_OFF   = 3'b111;
	localparam led_t LED_RED   = 3'b011;
	localparam led_t LED_GREEN = 3'b101;
	localparam led_t LED_BLUE  = 3'b110;

	localparam unit_t UNIT_MPU = 3'd1;
	localparam unit_t UNIT_PU  = 3'd2;
	localparam unit_t UNIT_W   = 3'd3;
	localparam unit_t UNIT_SSU = 3'd4;

	localparam int TRACK_MAX = 3;  // faults per visit, one per led slot

	localparam logic [47:0] HEAD_MPU = 48'h5550_4D2D_4953;  // "SI-MPU"
	localparam logic [39:0] HEAD_PU  = 40'h55_502D_4953;    // "SI-PU"
	localparam logic [31:0] HEAD_W   = 32'h572D_4953;       // "SI-W"
	localparam logic [47:0] HEAD_SSU = 48'h5553_532D_5246;  // "FR-SSU"

	localparam logic [47:0] TAIL_RED   = 48'h0A23_2D49_462D;  // "-FI-#\n"
	localparam logic [47:0] TAIL_GREEN = 48'h0A23_2D54_432D;  // "-CT-#\n"
	localparam logic [47:0] TAIL_BLUE  = 48'h0A23_2D53_432D;  // "-CS-#\n"

	function automatic led_t color_to_led(input color_t c);
		case (c)
			COLOR_RED:   color_to_led = LED_RED;
			COLOR_GREEN: color_to_led = LED_GREEN;
			COLOR_BLUE:  color_to_led = LED_BLUE;
			default:     color_to_led = LED_OFF;  // white and unused codes stay dark
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== rtl/led_slots.sv ====
// three led slots filled in order 1 to 3 and cleared by colour while blink mode hides but keeps them
`timescale 1ns/1ns
`default_nettype none

module led_slots (
	input  logic              CLOCK,
	input  logic              arst_n,
	input  logic              fill_req,
	input  logic              clear_req,
	input  fault_pkg::color_t req_color,
	input  logic              blink_run,
	input  logic              blink_on,
	input  fault_pkg::color_t blink_color,
	output logic              slot_free,
	output logic [1:0]        cleared_n,
	output fault_pkg::led_t   led1,
	output fault_pkg::led_t   led2,
	output fault_pkg::led_t   led3
);

	import fault_pkg::*;

	led_t       slots [3];  // stored fault leds
	led_t       req_led;
	led_t       blink_led;
	logic [1:0] match_n;    // slots showing req_led

	assign req_led   = color_to_led(req_color);
	assign blink_led = blink_on ? color_to_led(blink_color) : LED_OFF;
	assign slot_free = (slots[0] == LED_OFF) || (slots[1] == LED_OFF) || (slots[2] == LED_OFF);

	always_comb
	begin
		match_n = 2'd0;
		for (int i = 0; i < 3; i++)
		begin
			if (slots[i] == req_led)
				match_n = match_n + 2'd1;
		end
	end

	// count is ready alongside the request so the record can carry it
	assign cleared_n = clear_req ? match_n : 2'd0;

	always_ff @(posedge CLOCK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 3; i++)
				slots[i] <= LED_OFF;
		end
		else if (fill_req)
		begin
			if (slots[0] == LED_OFF)
				slots[0] <= req_led;
			else if (slots[1] == LED_OFF)
				slots[1] <= req_led;
			else if (slots[2] == LED_OFF)
				slots[2] <= req_led;
		end
		else if (clear_req)
		begin
			for (int i = 0; i < 3; i++)
			begin
				if (slots[i] == req_led)
					slots[i] <= LED_OFF;
			end
		end
	end

	assign led1 = blink_run ? blink_led : slots[0];
	assign led2 = blink_run ? blink_led : slots[1];
	assign led3 = blink_run ? blink_led : slots[2];

endmodule

`default_nettype wire

// ==== rtl/message_builder.sv ====
// record payload is only meaningful while msg_valid is high and unknown unit codes give an empty record
`timescale 1ns/1ns
`default_nettype none

module message_builder (
	input  logic                CLOCK,
	input  logic                arst_n,
	input  logic                report,
	input  fault_pkg::unit_t    report_unit,
	input  fault_pkg::color_t   report_color,
	input  logic [1:0]          cleared_n,
	output fault_pkg::msg_t     msg_data,
	output fault_pkg::nbytes_t  msg_bytes,
	output logic [2:0]          msg_repeat,
	output logic                msg_valid
);

	import fault_pkg::*;

	function automatic logic [47:0] color_tail(input color_t c);
		case (c)
			COLOR_RED:   color_tail = TAIL_RED;
			COLOR_GREEN: color_tail = TAIL_GREEN;
			COLOR_BLUE:  color_tail = TAIL_BLUE;
			default:     color_tail = '0;
		endcase
	endfunction

	logic [47:0] tail;
	msg_t        record;
	nbytes_t     nbytes;

	assign tail = color_tail(report_color);

	always_comb
	begin
		case (report_unit)
			UNIT_MPU:
			begin
				record = {tail, HEAD_MPU};
				nbytes = nbytes_t'(12);
			end
			UNIT_PU:
			begin
				record = {8'h00, tail, HEAD_PU};  // top byte unused
				nbytes = nbytes_t'(11);
			end
			UNIT_W:
			begin
				record = {16'h0000, tail, HEAD_W};
				nbytes = nbytes_t'(10);
			end
			UNIT_SSU:
			begin
				record = {tail, HEAD_SSU};
				nbytes = nbytes_t'(12);
			end
			default:
			begin
				record = '0;
				nbytes = '0;
			end
		endcase
	end

	always_ff @(posedge CLOCK or negedge arst_n)
	begin
		if (!arst_n)
			msg_valid <= 1'b0;
		else
			msg_valid <= report;  // one strobe per report
	end

	always_ff @(posedge CLOCK)
	begin
		if (report)
		begin
			msg_data   <= record;
			msg_bytes  <= nbytes;
			msg_repeat <= (report_unit == UNIT_SSU) ? {1'b0, cleared_n} : 3'd1;  // ssu may send 0
		end
	end

endmodule

`default_nettype wire

// ==== rtl/patrol_fsm.sv ====
// STOPPED is final until reset and confirms arriving while tx_done is low are dropped with no queue
`timescale 1ns/1ns
`default_nettype none

module patrol_fsm (
	input  logic                CLOCK,
	input  logic                arst_n,
	input  logic                in_scan,
	input  logic                is_stop,
	input  fault_pkg::unit_t    unit,
	input  logic                confirm,
	input  fault_pkg::color_t   confirm_color,
	input  logic                tx_done,
	input  logic                slot_free,
	output logic                fill_req,
	output logic                clear_req,
	output logic                report,
	output fault_pkg::color_t   req_color,
	output fault_pkg::unit_t    report_unit,
	output logic                blink_run,
	output fault_pkg::visits_t  visits_mpu,
	output fault_pkg::visits_t  visits_pu,
	output fault_pkg::visits_t  visits_w
);

	import fault_pkg::*;

	typedef enum logic [2:0] {IDLE, MPU, PU, W, SSU, STOPPED} state_t;

	state_t     state;
	color_t     last_reported;  // novelty reference
	tally_t     tally_mpu;
	tally_t     tally_pu;
	tally_t     tally_w;
	tally_t     patch_idx;      // patches seen this visit
	logic [1:0] track;          // faults accepted this visit
	logic       revisit;

	tally_t cur_tally;
	unit_t  cur_unit;
	tally_t idx_next;
	logic   in_fault_unit;
	logic   candidate;
	logic   new_patch;
	logic   accept;
	logic   refuse_full;

	always_comb
	begin
		case (state)
			MPU:
			begin
				cur_tally = tally_mpu;
				cur_unit  = UNIT_MPU;
			end
			PU:
			begin
				cur_tally = tally_pu;
				cur_unit  = UNIT_PU;
			end
			W:
			begin
				cur_tally = tally_w;
				cur_unit  = UNIT_W;
			end
			SSU:
			begin
				cur_tally = '0;
				cur_unit  = UNIT_SSU;
			end
			default:
			begin
				cur_tally = '0;
				cur_unit  = '0;
			end
		endcase
	end

	assign in_fault_unit = (state == MPU) || (state == PU) || (state == W);
	assign candidate     = confirm && (confirm_color != COLOR_WHITE) &&
	                       (confirm_color != last_reported) && tx_done;
	assign idx_next      = patch_idx + tally_t'(1);
	assign new_patch     = idx_next > cur_tally;  // not reported on an earlier visit
	assign accept        = in_fault_unit && candidate && new_patch &&
	                       (track < TRACK_MAX) && slot_free;
	assign refuse_full   = in_fault_unit && candidate && new_patch && (track >= TRACK_MAX);
	assign blink_run     = (state == STOPPED);

	always_ff @(posedge CLOCK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state         <= IDLE;
			last_reported <= COLOR_WHITE;
			tally_mpu     <= '0;
			tally_pu      <= '0;
			tally_w       <= '0;
			visits_mpu    <= visits_t'(1);
			visits_pu     <= visits_t'(1);
			visits_w      <= visits_t'(1);
			patch_idx     <= '0;
			track         <= '0;
			revisit       <= 1'b0;
			fill_req      <= 1'b0;
			clear_req     <= 1'b0;
			report        <= 1'b0;
			req_color     <= COLOR_WHITE;
			report_unit   <= '0;
		end
		else
		begin
			fill_req  <= 1'b0;
			clear_req <= 1'b0;
			report    <= 1'b0;
			if (confirm && (confirm_color == COLOR_WHITE))
				last_reported <= COLOR_WHITE;  // white gap rearms the same colour
			case (state)
				IDLE:
				begin
					if (is_stop)
						state <= STOPPED;
					else if (in_scan)
					begin
						case (unit)
							UNIT_MPU: if (visits_mpu != '0) state <= MPU;
							UNIT_PU:  if (visits_pu != '0) state <= PU;
							UNIT_W:   if (visits_w != '0) state <= W;
							UNIT_SSU: state <= SSU;
							default:  state <= IDLE;  // unknown unit code
						endcase
					end
				end
				MPU, PU, W:
				begin
					if (candidate)
						patch_idx <= idx_next;
					if (refuse_full)
						revisit <= 1'b1;  // more faults than one visit holds
					if (accept)
					begin
						track         <= track + 2'd1;
						last_reported <= confirm_color;
						report        <= 1'b1;
						fill_req      <= 1'b1;
						req_color     <= confirm_color;
						report_unit   <= cur_unit;
						case (state)
							MPU:     tally_mpu <= tally_mpu + tally_t'(1);
							PU:      tally_pu  <= tally_pu + tally_t'(1);
							default: tally_w   <= tally_w + tally_t'(1);
						endcase
					end
					if (!in_scan)
					begin
						state     <= IDLE;
						patch_idx <= '0;
						track     <= '0;
						revisit   <= 1'b0;
						case (state)
							MPU:     visits_mpu <= (revisit || refuse_full) ? 2'd1 : 2'd0;
							PU:      visits_pu  <= (revisit || refuse_full) ? 2'd1 : 2'd0;
							default: visits_w   <= (revisit || refuse_full) ? 2'd1 : 2'd0;
						endcase
					end
				end
				SSU:
				begin
					if (candidate)
					begin
						clear_req     <= 1'b1;  // resolve every matching led
						report        <= 1'b1;
						req_color     <= confirm_color;
						report_unit   <= cur_unit;
						last_reported <= confirm_color;
					end
					if (is_stop)
						state <= STOPPED;
					else if (!in_scan)
						state <= IDLE;
				end
				STOPPED: state <= STOPPED;
				default: state <= IDLE;
			endcase
		end
	end

	// a fill must find a dark slot in led_slots or the fault is lost
	a_fill_has_slot: assert property (@(posedge CLOCK) disable iff (!arst_n)
		fill_req |-> slot_free)
		else $error("fill requested with every slot lit");

endmodule

`default_nettype wire

// ==== testbench/fault_trace.txt ====
# op scan unit stop tx color count msg_valid bytes repeat data led1 led2 led3 v_mpu v_pu v_w
# all hex, op 0 drives count samples then checks, op 1 checks the blink order
0 0 0 0 1 0 0 0 0 0 0 7 7 7 1 1 1
0 1 1 0 1 0 0 0 0 0 0 7 7 7 1 1 1
0 1 1 0 1 1 2 0 0 0 0 7 7 7 1 1 1
0 1 1 0 1 0 2 0 0 0 0 7 7 7 1 1 1
0 1 1 0 1 1 4 1 c 1 0a232d49462d55504d2d4953 3 7 7 1 1 1
0 1 1 0 1 0 4 0 0 0 0 3 7 7 1 1 1
0 1 1 0 0 3 4 0 0 0 0 3 7 7 1 1 1
0 1 1 0 1 0 4 0 0 0 0 3 7 7 1 1 1
0 0 0 0 1 0 0 0 0 0 0 3 7 7 0 1 1
0 1 4 0 1 0 0 0 0 0 0 3 7 7 0 1 1
0 1 4 0 1 1 4 1 c 1 0a232d49462d5553532d5246 7 7 7 0 1 1
0 1 4 0 1 0 4 0 0 0 0 7 7 7 0 1 1
0 0 0 0 1 0 0 0 0 0 0 7 7 7 0 1 1
0 1 2 0 1 0 0 0 0 0 0 7 7 7 0 1 1
0 1 2 0 1 1 4 1 b 1 000a232d49462d55502d4953 3 7 7 0 1 1
0 1 2 0 1 0 4 0 0 0 0 3 7 7 0 1 1
0 1 2 0 1 3 4 1 b 1 000a232d53432d55502d4953 3 6 7 0 1 1
0 1 2 0 1 0 4 0 0 0 0 3 6 7 0 1 1
0 1 2 0 1 2 4 1 b 1 000a232d54432d55502d4953 3 6 5 0 1 1
0 1 2 0 1 0 4 0 0 0 0 3 6 5 0 1 1
0 1 2 0 1 2 4 0 0 0 0 3 6 5 0 1 1
0 1 2 0 1 0 4 0 0 0 0 3 6 5 0 1 1
0 0 0 0 1 0 0 0 0 0 0 3 6 5 0 1 1
0 1 4 0 1 0 0 0 0 0 0 3 6 5 0 1 1
0 1 4 0 1 1 4 1 c 1 0a232d49462d5553532d5246 7 6 5 0 1 1
0 1 4 0 1 0 4 0 0 0 0 7 6 5 0 1 1
0 1 4 0 1 3 4 1 c 1 0a232d53432d5553532d5246 7 7 5 0 1 1
0 1 4 0 1 0 4 0 0 0 0 7 7 5 0 1 1
0 0 0 0 1 0 0 0 0 0 0 7 7 5 0 1 1
0 1 2 0 1 0 0 0 0 0 0 7 7 5 0 1 1
0 1 2 0 1 1 4 0 0 0 0 7 7 5 0 1 1
0 1 2 0 1 0 4 0 0 0 0 7 7 5 0 1 1
0 1 2 0 1 3 4 0 0 0 0 7 7 5 0 1 1
0 1 2 0 1 0 4 0 0 0 0 7 7 5 0 1 1
0 1 2 0 1 2 4 0 0 0 0 7 7 5 0 1 1
0 1 2 0 1 0 4 0 0 0 0 7 7 5 0 1 1
0 1 2 0 1 2 4 1 b 1 000a232d54432d55502d4953 5 7 5 0 1 1
0 1 2 0 1 0 4 0 0 0 0 5 7 5 0 1 1
0 0 0 0 1 0 0 0 0 0 0 5 7 5 0 0 1
0 1 4 0 1 0 0 0 0 0 0 5 7 5 0 0 1
0 1 4 0 1 2 4 1 c 2 0a232d54432d5553532d5246 7 7 7 0 0 1
0 1 4 0 1 0 4 0 0 0 0 7 7 7 0 0 1
0 0 0 0 1 0 0 0 0 0 0 7 7 7 0 0 1
0 1 3 0 1 0 0 0 0 0 0 7 7 7 0 0 1
0 0 0 0 1 0 0 0 0 0 0 7 7 7 0 0 0
0 1 3 0 1 0 0 0 0 0 0 7 7 7 0 0 0
0 1 3 0 1 1 4 0 0 0 0 7 7 7 0 0 0
0 1 3 0 1 0 4 0 0 0 0 7 7 7 0 0 0
0 0 0 0 1 0 0 0 0 0 0 7 7 7 0 0 0
1 0 0 1 1 0 0 0 0 0 0 7 7 7 0 0 0

// ==== testbench/tb_fault_monitor.sv ====
// reads testbench/fault_trace.txt relative to the project root and runs with short blink timing
`timescale 1ns/1ns
`default_nettype none

module tb_fault_monitor;

	import fault_pkg::*;

	typedef struct packed {
		logic [3:0] op;       // 0 step, 1 blink order check
		logic       scan;
		unit_t      unit;
		logic       stop;
		logic       tx;
		color_t     color;
		logic [7:0] count;    // valid samples driven this step
		logic       mv;       // message expected
		nbytes_t    bytes;
		logic [2:0] rep;
		msg_t       data;
		led_t       l1;
		led_t       l2;
		led_t       l3;
		visits_t    vm;
		visits_t    vp;
		visits_t    vw;
	} step_t;

	localparam int BLINK_WAIT = 130;  // two phases plus slack

	logic     CLOCK;
	logic     arst_n;
	logic     in_scan;
	unit_t    unit;
	logic     is_stop;
	color_t   color;
	logic     color_valid;
	logic     tx_done;
	led_t     led1;
	led_t     led2;
	led_t     led3;
	msg_t     msg_data;
	nbytes_t  msg_bytes;
	logic [2:0] msg_repeat;
	logic     msg_valid;
	visits_t  visits_mpu;
	visits_t  visits_pu;
	visits_t  visits_w;

	step_t steps[$];
	int    errors;
	int    checks;
	int    cycle_cnt;
	int    limit;
	int    cur_step;

	fault_monitor_top #(
		.DEBOUNCE_LEN       (3),
		.BLINK_PHASE_CYCLES (60),
		.BLINK_STEP_CYCLES  (5)
	) i_dut (
		.CLOCK       (CLOCK),
		.arst_n      (arst_n),
		.in_scan     (in_scan),
		.unit        (unit),
		.is_stop     (is_stop),
		.color       (color),
		.color_valid (color_valid),
		.tx_done     (tx_done),
		.led1        (led1),
		.led2        (led2),
		.led3        (led3),
		.msg_data    (msg_data),
		.msg_bytes   (msg_bytes),
		.msg_repeat  (msg_repeat),
		.msg_valid   (msg_valid),
		.visits_mpu  (visits_mpu),
		.visits_pu   (visits_pu),
		.visits_w    (visits_w)
	);

	initial
	begin
		CLOCK = 1'b0;
		forever #2 CLOCK = ~CLOCK;  // 4 ns period
	end

	task automatic check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Mismatch %s at step %0d: got %h expected %h", name, cur_step, got, exp);
			errors++;
		end
	endtask

	task automatic load_trace();
		int         fd;
		int         n;
		int         a [16];
		logic [95:0] d;
		string      line;
		step_t      s;
		fd = $fopen("testbench/fault_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the trace file");
			errors++;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8], a[9], d,
					a[10], a[11], a[12], a[13], a[14], a[15]);
				if (n == 17)  // comment and blank lines skipped
				begin
					s.op    = a[0];
					s.scan  = a[1];
					s.unit  = a[2];
					s.stop  = a[3];
					s.tx    = a[4];
					s.color = a[5];
					s.count = a[6];
					s.mv    = a[7];
					s.bytes = a[8];
					s.rep   = a[9];
					s.data  = d;
					s.l1    = a[10];
					s.l2    = a[11];
					s.l3    = a[12];
					s.vm    = a[13];
					s.vp    = a[14];
					s.vw    = a[15];
					steps.push_back(s);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_leds_visits(input step_t s);
		check_value("led1", led1, s.l1);
		check_value("led2", led2, s.l2);
		check_value("led3", led3, s.l3);
		check_value("visits_mpu", visits_mpu, s.vm);
		check_value("visits_pu", visits_pu, s.vp);
		check_value("visits_w", visits_w, s.vw);
	endtask

	// drive one step then watch a short window for the record strobe
	task automatic run_step(input step_t s);
		int  seen;
		msg_t got_data;
		nbytes_t got_bytes;
		logic [2:0] got_rep;
		seen = 0;
		got_data = '0;
		got_bytes = '0;
		got_rep = '0;
		@(negedge CLOCK);
		in_scan = s.scan;
		unit    = s.unit;
		is_stop = s.stop;
		tx_done = s.tx;
		for (int i = 0; i < s.count; i++)
		begin
			color       = s.color;
			color_valid = 1'b1;
			@(negedge CLOCK);
		end
		color_valid = 1'b0;
		repeat (5)
		begin
			@(negedge CLOCK);
			if (msg_valid)
			begin
				seen++;
				got_data  = msg_data;
				got_bytes = msg_bytes;
				got_rep   = msg_repeat;
			end
		end
		check_value("msg_valid count", seen, s.mv);
		if (s.mv && seen == 1)
		begin
			check_value("msg_data", got_data, s.data);
			check_value("msg_bytes", got_bytes, s.bytes);
			check_value("msg_repeat", got_rep, s.rep);
		end
		check_leds_visits(s);
	endtask

	task automatic wait_all_leds(input led_t c, input string what);
		int n;
		n = 0;
		while ((led1 !== c || led2 !== c || led3 !== c) && n < BLINK_WAIT)
		begin
			@(negedge CLOCK);
			n++;
		end
		checks++;
		assert (n < BLINK_WAIT)
		else
		begin
			$display("LEDs never all showed %s during the blink at step %0d", what, cur_step);
			errors++;
		end
	endtask

	// end of run sequence: red, green, blue, dark, then lit again
	task automatic check_blink(input step_t s);
		@(negedge CLOCK);
		in_scan = s.scan;
		unit    = s.unit;
		is_stop = s.stop;
		tx_done = s.tx;
		wait_all_leds(LED_RED, "red");
		wait_all_leds(LED_GREEN, "green");
		wait_all_leds(LED_BLUE, "blue");
		wait_all_leds(LED_OFF, "off");
		wait_all_leds(LED_RED, "red again");
		check_value("visits_mpu", visits_mpu, s.vm);
		check_value("visits_pu", visits_pu, s.vp);
		check_value("visits_w", visits_w, s.vw);
	endtask

	initial
	begin
		wait (limit != 0);
		while (cycle_cnt < limit)
		begin
			@(posedge CLOCK);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the trace did not complete", cycle_cnt);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		int budget;
		arst_n      = 1'b0;
		in_scan     = 1'b0;
		unit        = '0;
		is_stop     = 1'b0;
		color       = COLOR_WHITE;
		color_valid = 1'b0;
		tx_done     = 1'b1;
		errors      = 0;
		checks      = 0;
		cycle_cnt   = 0;
		limit       = 0;
		cur_step    = 0;
		load_trace();
		budget = 10;
		foreach (steps[i])
			budget += (steps[i].op == 4'd1) ? 5 * BLINK_WAIT + 2 : steps[i].count + 6;
		limit = budget + 50;
		repeat (10) @(negedge CLOCK);
		arst_n = 1'b1;
		foreach (steps[i])
		begin
			cur_step = i;
			if (steps[i].op == 4'd1)
				check_blink(steps[i]);
			else
				run_step(steps[i]);
		end
		checks++;
		assert (steps.size() > 0)
		else
		begin
			$display("the trace held no steps");
			errors++;
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
